// File: dv/exec_unit_tb.sv
// --------------------------------------------------------------------------
// Random-stimulus testbench for the execute stage, checked against a model
// Builds the DUT with 2 multiplier bits per step, so mul takes 16 steps
// --------------------------------------------------------------------------

module exec_unit_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int n_ops         = 400;
  localparam int clk_period    = 4;
  localparam int bits_per_step = 2;
  // Accept to first w_val cycle, minus one
  localparam int alu_latency   = 1;
  localparam int mul_latency   = 1 + uarch_pkg::data_bits / bits_per_step;

  logic               clk;
  logic               rst_n;
  logic               d_val;
  logic               d_rdy;
  xmsg_pkg::d_x_msg_t d_msg;
  logic               w_val;
  logic               w_rdy;
  xmsg_pkg::x_w_msg_t w_msg;

  // Separate LCG streams for D side and W side
  logic [31:0]        stim_rng;
  logic [31:0]        rdy_rng;
  int                 cycle;
  int                 done_cnt;
  bit                 head_seen;
  bit                 hold_pending;
  xmsg_pkg::x_w_msg_t held_msg;

  // Model, one entry per accepted uop, oldest first
  xmsg_pkg::x_w_msg_t exp_q[$];
  int                 acc_cycle_q[$];
  int                 exp_lat_q[$];

  exec_unit #(
    .p_mul_bits_per_step (bits_per_step)
  ) i_dut (
    .clk   (clk),
    .rst_n (rst_n),
    .d_val (d_val),
    .d_rdy (d_rdy),
    .d_msg (d_msg),
    .w_val (w_val),
    .w_rdy (w_rdy),
    .w_msg (w_msg)
  );

  always #(clk_period / 2) clk = ~clk;

  // --------------------------------------------------------------------------
  // Random numbers
  // --------------------------------------------------------------------------
  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Upper half only, low LCG bits cycle too fast
  function automatic logic [15:0] stim_rand();
    stim_rng = lcg_step(stim_rng);
    return stim_rng[31:16];
  endfunction

  // Corner values mixed into random operands
  function automatic logic [uarch_pkg::data_bits-1:0] pick_operand();
    logic [15:0] sel;
    logic [15:0] hi;
    logic [15:0] lo;
    sel = stim_rand();
    hi  = stim_rand();
    lo  = stim_rand();
    case (sel % 8)
      0:       return '0;
      1:       return '1;
      2:       return 32'h8000_0000;
      default: return {hi, lo};
    endcase
  endfunction

  function automatic xmsg_pkg::d_x_msg_t random_uop(int idx);
    xmsg_pkg::d_x_msg_t m;
    logic [15:0]        pc_hi;
    logic [15:0]        pc_lo;
    logic [15:0]        w;
    pc_hi     = stim_rand();
    pc_lo     = stim_rand();
    m.pc      = {pc_hi, pc_lo[15:2], 2'b00};
    m.seq_num = idx[4:0];
    m.op1     = pick_operand();
    m.op2     = pick_operand();
    w         = stim_rand();
    // x0 now and then, to see wen drop
    m.waddr   = (w % 5 == 0) ? '0 : w[8:4];
    // About one in six is a mul
    if (stim_rand() % 6 == 0) m.uop = uarch_pkg::uop_mul;
    else                      m.uop = uarch_pkg::rv_uop'(4'(stim_rand() % 11));
    return m;
  endfunction

  // --------------------------------------------------------------------------
  // Reference model, RV32I / M rules
  // --------------------------------------------------------------------------
  function automatic xmsg_pkg::x_w_msg_t expected_wb(xmsg_pkg::d_x_msg_t m);
    xmsg_pkg::x_w_msg_t r;
    logic [4:0]         sh;
    sh        = m.op2[4:0];
    r.pc      = m.pc;
    r.seq_num = m.seq_num;
    r.waddr   = m.waddr;
    r.wen     = (m.waddr != 0);
    case (m.uop)
      uarch_pkg::uop_add:  r.wdata = m.op1 + m.op2;
      uarch_pkg::uop_sub:  r.wdata = m.op1 - m.op2;
      uarch_pkg::uop_and:  r.wdata = m.op1 & m.op2;
      uarch_pkg::uop_or:   r.wdata = m.op1 | m.op2;
      uarch_pkg::uop_xor:  r.wdata = m.op1 ^ m.op2;
      uarch_pkg::uop_sll:  r.wdata = m.op1 << sh;
      uarch_pkg::uop_srl:  r.wdata = m.op1 >> sh;
      // Logical shift, then refill the top with the sign
      uarch_pkg::uop_sra:  r.wdata = (m.op1 >> sh) |
                                     (m.op1[31] ? ~(32'hffff_ffff >> sh) : 32'h0);
      uarch_pkg::uop_slt:  r.wdata = ($signed(m.op1) < $signed(m.op2)) ? 32'd1 : 32'd0;
      uarch_pkg::uop_sltu: r.wdata = (m.op1 < m.op2) ? 32'd1 : 32'd0;
      uarch_pkg::uop_lui:  r.wdata = m.op2;
      uarch_pkg::uop_mul:  r.wdata = m.op1 * m.op2;
      default:             r.wdata = 'x;
    endcase
    return r;
  endfunction

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  task automatic report_error(string what);
    $display("ERR @ %0t: %s", $time, what);
    $display("** FAIL **");
    $fatal(1);
  endtask

  task automatic compare_msg(xmsg_pkg::x_w_msg_t got, xmsg_pkg::x_w_msg_t exp, string what);
    if (got !== exp) begin
      report_error({
        $sformatf("%s got pc=%h seq=%0d wa=%0d wd=%h wen=%b",
                  what, got.pc, got.seq_num, got.waddr, got.wdata, got.wen),
        $sformatf(" exp pc=%h seq=%0d wa=%0d wd=%h wen=%b",
                  exp.pc, exp.seq_num, exp.waddr, exp.wdata, exp.wen)});
    end
  endtask

  task automatic compare_latency(int got, int exp, string what);
    if (got != exp) begin
      report_error($sformatf("%s got %0d cycles, expected %0d", what, got, exp));
    end
  endtask

  // Random back-pressure, w_rdy low about a third of the time
  always @(posedge clk) begin
    if (!rst_n) begin
      w_rdy <= 1'b0;
    end else begin
      rdy_rng = lcg_step(rdy_rng);
      w_rdy <= (rdy_rng[31:16] % 3 != 0);
    end
  end

  // Monitor, sees pre-edge values of every signal
  always @(posedge clk) begin
    cycle++;
    if (rst_n) begin
      if (d_val && d_rdy) begin
        exp_q.push_back(expected_wb(d_msg));
        acc_cycle_q.push_back(cycle);
        exp_lat_q.push_back(d_msg.uop == uarch_pkg::uop_mul ? mul_latency : alu_latency);
      end
      if (w_val) begin
        if (exp_q.size() == 0) begin
          report_error("W result seen with no uop outstanding");
        end else begin
          if (d_rdy) report_error("d_rdy high while a result waits on W");
          // Latency counted once, on the first w_val cycle
          if (!head_seen) begin
            compare_latency(cycle - acc_cycle_q[0] - 1, exp_lat_q[0], "w_val latency");
            head_seen = 1'b1;
          end
          if (hold_pending) compare_msg(w_msg, held_msg, "w_msg moved under back-pressure");
          if (w_rdy) begin
            compare_msg(w_msg, exp_q[0], "writeback");
            void'(exp_q.pop_front());
            void'(acc_cycle_q.pop_front());
            void'(exp_lat_q.pop_front());
            done_cnt++;
            head_seen    = 1'b0;
            hold_pending = 1'b0;
          end else begin
            hold_pending = 1'b1;
            held_msg     = w_msg;
          end
        end
      end else if (hold_pending) begin
        report_error("w_val dropped before w_rdy");
      end
    end
  end

  // Watchdog, worst case of every op a mul plus slack for gaps and stalls
  initial begin
    #(n_ops * (mul_latency + 8) * clk_period);
    $display("Timeout: run went past its time budget with %0d of %0d ops still outstanding",
             n_ops - done_cnt, n_ops);
    $display("** FAIL **");
    $fatal(1);
  end

  // --------------------------------------------------------------------------
  // Reset and D-side driver
  // --------------------------------------------------------------------------
  initial begin
    int gap;
    clk          = 1'b0;
    rst_n        = 1'b0;
    d_val        = 1'b0;
    d_msg        = '0;
    w_rdy        = 1'b0;
    stim_rng     = 32'd81;
    rdy_rng      = ~32'd81;
    cycle        = 0;
    done_cnt     = 0;
    head_seen    = 1'b0;
    hold_pending = 1'b0;
    repeat (3) @(posedge clk);
    rst_n <= 1'b1;
    @(posedge clk);
    if (w_val || !d_rdy) report_error("after reset w_val not low or d_rdy not high");
    for (int i = 0; i < n_ops; i++) begin
      // Idle gaps of 0 to 3 cycles on about a third of the ops
      gap = (stim_rand() % 3 == 0) ? int'(stim_rand() % 4) : 0;
      repeat (gap) @(posedge clk);
      @(posedge clk);
      d_val <= 1'b1;
      d_msg <= random_uop(i);
      do @(posedge clk); while (!d_rdy);
      d_val <= 1'b0;
    end
    wait (done_cnt == n_ops);
    repeat (2) @(posedge clk);
    // Last writeback must leave the stage idle and ready
    if (!w_val && d_rdy) begin
      $display("** PASS **");
      $finish;
    end else begin
      report_error("stage not back in idle after the last writeback");
    end
  end

endmodule

// File: files.f
hw/uarch_pkg.sv
hw/xmsg_pkg.sv
hw/exec_ctrl.sv
hw/mul_step_counter.sv
hw/alu_datapath.sv
hw/mul_iter.sv
hw/exec_unit.sv
dv/exec_unit_tb.sv

// File: hw/alu_datapath.sv
// --------------------------------------------------------------------------
// Operand register, single-cycle ALU and writeback message register
// Shift amounts use op2[4:0], so this assumes a 32-bit datapath
// w_msg holds its value until the next res_capture
// --------------------------------------------------------------------------

module alu_datapath (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            load,
  input  xmsg_pkg::d_x_msg_t              d_msg,
  input  logic                            res_capture,
  input  logic [uarch_pkg::data_bits-1:0] mul_product,
  output logic [uarch_pkg::data_bits-1:0] op1,
  output logic [uarch_pkg::data_bits-1:0] op2,
  output logic                            is_mul,
  output xmsg_pkg::x_w_msg_t              w_msg
);

  xmsg_pkg::d_x_msg_t              x_msg;
  logic [uarch_pkg::data_bits-1:0] alu_result;
  logic [4:0]                      shamt;
  xmsg_pkg::x_w_msg_t              w_msg_next;

  // --------------------------------------------------------------------------
  // Captured uop
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (load) begin
      x_msg <= d_msg;
    end
  end

  assign op1    = x_msg.op1;
  assign op2    = x_msg.op2;
  assign is_mul = (x_msg.uop == uarch_pkg::uop_mul);
  assign shamt  = x_msg.op2[4:0];

  // --------------------------------------------------------------------------
  // Single-cycle ALU
  // --------------------------------------------------------------------------
  always_comb begin
    alu_result = '0;
    case (x_msg.uop)
      uarch_pkg::uop_add:  alu_result = op1 + op2;
      uarch_pkg::uop_sub:  alu_result = op1 - op2;
      uarch_pkg::uop_and:  alu_result = op1 & op2;
      uarch_pkg::uop_or:   alu_result = op1 | op2;
      uarch_pkg::uop_xor:  alu_result = op1 ^ op2;
      uarch_pkg::uop_sll:  alu_result = op1 << shamt;
      uarch_pkg::uop_srl:  alu_result = op1 >> shamt;
      uarch_pkg::uop_sra:  alu_result = $signed(op1) >>> shamt;
      // Compares give 0 or 1
      uarch_pkg::uop_slt:  alu_result = {{(uarch_pkg::data_bits-1){1'b0}},
                                         $signed(op1) < $signed(op2)};
      uarch_pkg::uop_sltu: alu_result = {{(uarch_pkg::data_bits-1){1'b0}},
                                         op1 < op2};
      uarch_pkg::uop_lui:  alu_result = op2;
      // Mul comes from the multiplier
      default:             alu_result = '0;
    endcase
  end

  // --------------------------------------------------------------------------
  // Writeback message
  // --------------------------------------------------------------------------
  always_comb begin
    w_msg_next.pc      = x_msg.pc;
    w_msg_next.seq_num = x_msg.seq_num;
    w_msg_next.waddr   = x_msg.waddr;
    w_msg_next.wdata   = is_mul ? mul_product : alu_result;
    // x0 is never written
    w_msg_next.wen     = (x_msg.waddr != '0);
  end

  // Writeback message register, wen low out of reset
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      w_msg.wen <= 1'b0;
    end else if (res_capture) begin
      w_msg <= w_msg_next;
    end
  end

endmodule

// File: hw/exec_ctrl.sv
// --------------------------------------------------------------------------
// Execute stage control, one op in flight at a time
// ALU ops respond one cycle after accept, mul after 1 + step count cycles
// d_rdy is only high in idle, so no op is taken while a result waits on W
// --------------------------------------------------------------------------

module exec_ctrl (
  input  logic clk,
  input  logic rst_n,
  input  logic d_val,
  output logic d_rdy,
  output logic w_val,
  input  logic w_rdy,
  input  logic is_mul,
  input  logic last_step,
  output logic load,
  output logic mul_start,
  output logic res_capture
);

  typedef enum logic [1:0] {
    s_idle,
    s_decode,
    s_mul,
    s_resp
  } state_e;

  state_e state;
  state_e state_next;

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state <= s_idle;
    end else begin
      state <= state_next;
    end
  end

  // Next state
  always_comb begin
    state_next = state;
    case (state)
      s_idle:   if (d_val)     state_next = s_decode;
      // Captured uop is visible here, pick the path
      s_decode: state_next = is_mul ? s_mul : s_resp;
      s_mul:    if (last_step) state_next = s_resp;
      // Hold result until writeback takes it
      s_resp:   if (w_rdy)     state_next = s_idle;
      default:  state_next = s_idle;
    endcase
  end

  // --------------------------------------------------------------------------
  // Outputs, all decoded from state
  // --------------------------------------------------------------------------
  assign d_rdy     = (state == s_idle);
  assign load      = d_rdy && d_val;
  assign mul_start = (state == s_decode) && is_mul;
  assign w_val     = (state == s_resp);

  // ALU result right after decode, product on the final step
  assign res_capture = ((state == s_decode) && !is_mul) ||
                       ((state == s_mul) && last_step);

  // --------------------------------------------------------------------------
  // Checks
  // --------------------------------------------------------------------------
  // Counter's final step must land in the mul state
  a_last_step_in_mul: assert property (@(posedge clk) disable iff (!rst_n)
    last_step |-> (state == s_mul));

  // Captured uop must not change while an op is in flight
  a_uop_held: assert property (@(posedge clk) disable iff (!rst_n)
    (state == s_mul || state == s_resp) |-> $stable(is_mul));

endmodule

// File: hw/exec_unit.sv
// --------------------------------------------------------------------------
// Integer execute stage, val/rdy on both D and W channels
// One op in flight, ALU latency 1, mul latency 1 + 32 / bits per step
// p_mul_bits_per_step is one of 1, 2, 4, 8
// --------------------------------------------------------------------------

module exec_unit #(
  parameter int p_mul_bits_per_step = 2
) (
  input  logic               clk,
  input  logic               rst_n,
  input  logic               d_val,
  output logic               d_rdy,
  input  xmsg_pkg::d_x_msg_t d_msg,
  output logic               w_val,
  input  logic               w_rdy,
  output xmsg_pkg::x_w_msg_t w_msg
);

  // Control to datapath
  logic load;
  logic mul_start;
  logic res_capture;
  logic is_mul;
  logic last_step;

  // Operands and product
  logic [uarch_pkg::data_bits-1:0] op1;
  logic [uarch_pkg::data_bits-1:0] op2;
  logic [uarch_pkg::data_bits-1:0] mul_product;

  // --------------------------------------------------------------------------
  // Control
  // --------------------------------------------------------------------------
  exec_ctrl i_ctrl (
    .clk         (clk),
    .rst_n       (rst_n),
    .d_val       (d_val),
    .d_rdy       (d_rdy),
    .w_val       (w_val),
    .w_rdy       (w_rdy),
    .is_mul      (is_mul),
    .last_step   (last_step),
    .load        (load),
    .mul_start   (mul_start),
    .res_capture (res_capture)
  );

  mul_step_counter #(
    .p_mul_bits_per_step (p_mul_bits_per_step)
  ) i_step_cnt (
    .clk       (clk),
    .rst_n     (rst_n),
    .start     (mul_start),
    .last_step (last_step)
  );

  // --------------------------------------------------------------------------
  // Datapaths
  // --------------------------------------------------------------------------
  alu_datapath i_alu (
    .clk         (clk),
    .rst_n       (rst_n),
    .load        (load),
    .d_msg       (d_msg),
    .res_capture (res_capture),
    .mul_product (mul_product),
    .op1         (op1),
    .op2         (op2),
    .is_mul      (is_mul),
    .w_msg       (w_msg)
  );

  mul_iter #(
    .p_mul_bits_per_step (p_mul_bits_per_step)
  ) i_mul (
    .clk     (clk),
    .rst_n   (rst_n),
    .start   (mul_start),
    .op1     (op1),
    .op2     (op2),
    .product (mul_product)
  );

endmodule

// File: hw/mul_iter.sv
// --------------------------------------------------------------------------
// Iterative shift-add multiplier, low half of the product only
// p_mul_bits_per_step must divide the data width
// product is valid combinationally during the final step cycle
// --------------------------------------------------------------------------

module mul_iter #(
  parameter int p_mul_bits_per_step = 2
) (
  input  logic                            clk,
  input  logic                            rst_n,
  input  logic                            start,
  input  logic [uarch_pkg::data_bits-1:0] op1,
  input  logic [uarch_pkg::data_bits-1:0] op2,
  output logic [uarch_pkg::data_bits-1:0] product
);

  logic [uarch_pkg::data_bits-1:0] mcand;
  logic [uarch_pkg::data_bits-1:0] mplier;
  logic [uarch_pkg::data_bits-1:0] acc;
  logic [uarch_pkg::data_bits-1:0] step_term;

  // --------------------------------------------------------------------------
  // Partial product for this step
  // --------------------------------------------------------------------------
  // mcand times low multiplier bits, as shifted adds
  always_comb begin
    step_term = '0;
    for (int i = 0; i < p_mul_bits_per_step; i++) begin
      if (mplier[i]) step_term = step_term + (mcand << i);
    end
  end

  // Current step folded in, so the last step needs no extra cycle
  assign product = acc + step_term;

  // --------------------------------------------------------------------------
  // Iteration registers
  // --------------------------------------------------------------------------
  // Keeps stepping when idle, harmless once mplier drains to zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      mcand  <= '0;
      mplier <= '0;
      acc    <= '0;
    end else if (start) begin
      mcand  <= op1;
      mplier <= op2;
      acc    <= '0;
    end else begin
      mcand  <= mcand << p_mul_bits_per_step;
      mplier <= mplier >> p_mul_bits_per_step;
      acc    <= product;
    end
  end

endmodule

// File: hw/mul_step_counter.sv
// --------------------------------------------------------------------------
// Step counter for the iterative multiplier
// last_step is high during the final step cycle, start must not overlap
// --------------------------------------------------------------------------

module mul_step_counter #(
  parameter int p_mul_bits_per_step = 2
) (
  input  logic clk,
  input  logic rst_n,
  input  logic start,
  output logic last_step
);

  // Steps per multiply
  localparam int steps    = uarch_pkg::data_bits / p_mul_bits_per_step;
  localparam int cnt_bits = $clog2(steps);

  logic [cnt_bits-1:0] count;
  logic                busy;

  // Down-count from steps-1, stop after zero
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      count <= '0;
      busy  <= 1'b0;
    end else if (start) begin
      count <= cnt_bits'(steps - 1);
      busy  <= 1'b1;
    end else if (busy) begin
      if (count == '0) busy <= 1'b0;
      else             count <= count - 1'b1;
    end
  end

  assign last_step = busy && (count == '0);

  // Control only restarts after the previous multiply has finished
  a_no_restart: assert property (@(posedge clk) disable iff (!rst_n)
    start |-> !busy);

endmodule

// File: hw/uarch_pkg.sv
// --------------------------------------------------------------------------
// Microarchitecture widths and uop encoding for the integer execute stage
// Widths are fixed constants here, so one build means one configuration
// --------------------------------------------------------------------------

package uarch_pkg;

  // Datapath widths
  localparam int data_bits     = 32;
  localparam int addr_bits     = 32;
  localparam int seq_bits      = 5;
  localparam int reg_addr_bits = 5;

  // ------------------------------------------------------------------------
  // Micro-op encoding, as sent by decode
  // ------------------------------------------------------------------------
  typedef enum logic [3:0] {
    uop_add,
    uop_sub,
    uop_and,
    uop_or,
    uop_xor,
    uop_sll,
    uop_srl,
    uop_sra,
    uop_slt,
    uop_sltu,
    uop_lui,   // Copies op2, decode has already shifted the immediate
    uop_mul    // Low half of the product only
  } rv_uop;

endpackage

// File: hw/xmsg_pkg.sv
// --------------------------------------------------------------------------
// Message formats on the D and W channels of the execute stage
// Field order sets the packed layout, MSB first
// --------------------------------------------------------------------------

package xmsg_pkg;

  // ------------------------------------------------------------------------
  // Decode to execute, 110 bits
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [uarch_pkg::addr_bits-1:0]     pc;
    logic [uarch_pkg::seq_bits-1:0]      seq_num;
    logic [uarch_pkg::data_bits-1:0]     op1;
    logic [uarch_pkg::data_bits-1:0]     op2;
    logic [uarch_pkg::reg_addr_bits-1:0] waddr;
    uarch_pkg::rv_uop                    uop;
  } d_x_msg_t;

  // ------------------------------------------------------------------------
  // Execute to writeback, 75 bits
  // ------------------------------------------------------------------------
  typedef struct packed {
    logic [uarch_pkg::addr_bits-1:0]     pc;
    logic [uarch_pkg::seq_bits-1:0]      seq_num;
    logic [uarch_pkg::reg_addr_bits-1:0] waddr;
    logic [uarch_pkg::data_bits-1:0]     wdata;
    // Low for writes to x0
    logic                                wen;
  } x_w_msg_t;

endpackage
